// File: compile.f
common/xt_periph_pkg.sv
hdl/port_decoder.sv
ems/ems_mapper.sv
hdl/port_latches.sv
hdl/read_mux.sv
hdl/xt_peripherals.sv
test/bus_checker.sv
test/tb_xt_peripherals.sv

// File: Bender.yml
package:
  name: xt_peripherals

sources:
  # Shared package first
  - files:
      - common/xt_periph_pkg.sv
  # RTL
  - files:
      - hdl/port_decoder.sv
      - ems/ems_mapper.sv
      - hdl/port_latches.sv
      - hdl/read_mux.sv
      - hdl/xt_peripherals.sv
  # Testbench
  - target: test
    files:
      - test/bus_checker.sv
      - test/tb_xt_peripherals.sv

// File: test/tb_xt_peripherals.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the XT peripheral port block
// Clock, reset, CPU bus cycles and run timeout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module tb_xt_peripherals;

    logic                           clock;
    logic                           reset;
    xt_periph_pkg::cpu_bus_t        cpu_bus;
    logic                           tandy_video;
    logic                           ems_enable;
    logic [1:0]                     ems_base_sel;
    xt_periph_pkg::data_t           data;
    logic                           data_valid;
    logic [3:0]                     ems_win;
    xt_periph_pkg::ems_page_t [3:0] ems_map;
    logic [3:0]                     ems_ena;

    int          seed;
    int          op_count = 0;
    int          cycle_count = 0;
    int          error_count;
    int          check_count;
    logic [31:0] rnd;
    logic [3:0]  nibble;

    xt_peripherals #(
        .EMS_PORT       (xt_periph_pkg::EMS_PORT_DEFAULT),
        .LPT_PORT       (xt_periph_pkg::LPT_PORT_DEFAULT),
        .NMI_PORT       (xt_periph_pkg::NMI_PORT_DEFAULT)
    ) u_xt_peripherals (
        .clock          (clock),
        .reset          (reset),
        .cpu_bus_i      (cpu_bus),
        .data_o         (data),
        .data_valid_o   (data_valid),
        .tandy_video_i  (tandy_video),
        .ems_enable_i   (ems_enable),
        .ems_base_sel_i (ems_base_sel),
        .ems_win_o      (ems_win),
        .ems_map_o      (ems_map),
        .ems_ena_o      (ems_ena)
    );

    bus_checker u_bus_checker (
        .clock          (clock),
        .reset          (reset),
        .cpu_bus_i      (cpu_bus),
        .tandy_video_i  (tandy_video),
        .ems_enable_i   (ems_enable),
        .ems_base_sel_i (ems_base_sel),
        .data_i         (data),
        .data_valid_i   (data_valid),
        .ems_win_i      (ems_win),
        .ems_map_i      (ems_map),
        .ems_ena_i      (ems_ena),
        .error_count_o  (error_count),
        .check_count_o  (check_count)
    );

    always #5 clock = ~clock;

    // Limit grows with every issued bus operation
    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > 20 * op_count + 100) begin
            $display("Timeout: run exceeded %0d cycles, %0d checks, %0d errors",
                     cycle_count, check_count, error_count);
            $display("Checks failed");
            $finish;
        end
    end

    // Bus tasks start and end on a falling edge
    task automatic release_bus();
        cpu_bus.io_read_n        = 1'b1;
        cpu_bus.io_write_n       = 1'b1;
        cpu_bus.memory_read_n    = 1'b1;
        cpu_bus.address_enable_n = 1'b1;
    endtask

    task automatic io_write(input xt_periph_pkg::port_addr_t port,
                            input xt_periph_pkg::data_t value);
        cpu_bus.address          = {4'h0, port};
        cpu_bus.write_data       = value;
        cpu_bus.io_write_n       = 1'b0;
        cpu_bus.address_enable_n = 1'b0;
        op_count++;
        @(negedge clock);
        release_bus();
    endtask

    // Port in the low 16 bits, upper bits are free for I/O cycles
    task automatic io_read(input xt_periph_pkg::addr_t addr);
        cpu_bus.address          = addr;
        cpu_bus.io_read_n        = 1'b0;
        cpu_bus.address_enable_n = 1'b0;
        op_count++;
        repeat (2) @(negedge clock);
        release_bus();
    endtask

    task automatic mem_access(input xt_periph_pkg::addr_t addr);
        cpu_bus.address          = addr;
        cpu_bus.memory_read_n    = 1'b0;
        cpu_bus.address_enable_n = 1'b0;
        op_count++;
        @(negedge clock);
        release_bus();
    endtask

    task automatic idle_cycles(input int count);
        repeat (count) @(negedge clock);
    endtask

    task automatic read_all_pages();
        for (int i = 0; i < 4; i++)
            io_read(xt_periph_pkg::EMS_PORT_DEFAULT + i);
        idle_cycles(1);
    endtask

    initial begin
        seed         = 11060;
        clock        = 1'b0;
        reset        = 1'b1;
        tandy_video  = 1'b0;
        ems_enable   = 1'b0;
        ems_base_sel = 2'd0;
        cpu_bus      = '0;
        release_bus();
        repeat (8) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        idle_cycles(2);

        // Reset values
        io_read(16'h0378);
        tandy_video = 1'b1;
        io_read(16'h00A0);
        mem_access(20'hA4000);
        mem_access(20'hA8123);
        idle_cycles(1);

        // Printer latch and NMI mask
        for (int i = 0; i < 8; i++) begin
            rnd = $random(seed);
            io_write(16'h0378, rnd[7:0]);
            io_read(16'h0378);
        end
        for (int i = 0; i < 8; i++) begin
            rnd = $random(seed);
            io_write(16'h00A0 + i, rnd[7:0]);
            io_read(16'h00A0 + (i + 5) % 8);
        end
        tandy_video = 1'b0;
        io_read(16'h00A4);
        io_write(16'h00A2, 8'h5A);
        idle_cycles(1);
        tandy_video = 1'b1;
        io_read(16'h00A2);

        // EMS write rule
        ems_enable = 1'b1;
        for (int i = 0; i < 4; i++)
            io_write(16'h0260 + i, 8'h03 + 8'h1D * i);
        idle_cycles(2);
        read_all_pages();
        io_write(16'h0261, 8'h90);
        io_write(16'h0262, 8'hFF);
        io_write(16'h0263, 8'hFE);
        io_write(16'h0260, 8'h7F);
        idle_cycles(2);
        read_all_pages();
        for (int i = 0; i < 12; i++) begin
            rnd = $random(seed);
            io_write(16'h0260 + rnd[9:8], rnd[7:0]);
            idle_cycles(2);
            io_read(16'h0260 + rnd[9:8]);
        end
        ems_enable = 1'b0;
        io_write(16'h0260, 8'h12);
        io_read(16'h0260);
        idle_cycles(2);
        ems_enable = 1'b1;
        read_all_pages();

        // Window selects over all bases and slots
        io_write(16'h0260, 8'h11);
        io_write(16'h0261, 8'hFF);
        io_write(16'h0262, 8'h22);
        io_write(16'h0263, 8'h33);
        idle_cycles(2);
        for (int sel = 0; sel < 4; sel++) begin
            ems_base_sel = sel[1:0];
            for (int n = 10; n < 14; n++) begin
                nibble = n[3:0];
                for (int s = 0; s < 4; s++) begin
                    rnd = $random(seed);
                    mem_access({nibble, s[1:0], rnd[13:0]});
                end
                // I/O cycle whose upper address bits fall in the window range
                io_read({nibble, 16'h0262});
            end
        end

        // Back-to-back EMS writes
        io_write(16'h0260, 8'h44);
        io_write(16'h0263, 8'h55);
        io_write(16'h0261, 8'h66);
        io_write(16'h0261, 8'hC3);
        io_write(16'h0262, 8'hFF);
        io_write(16'h0262, 8'h85);
        idle_cycles(2);
        read_all_pages();
        for (int s = 0; s < 4; s++)
            mem_access({4'hD, s[1:0], 14'h0100});
        idle_cycles(3);

        $display("Run finished: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0 && check_count > 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: test/bus_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus checker for the XT peripheral port block
// Reference model of latches and EMS pages, compares
// read-back, page registers and window selects
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module bus_checker (
    input  logic                                   clock,
    input  logic                                   reset,
    input  xt_periph_pkg::cpu_bus_t                cpu_bus_i,
    input  logic                                   tandy_video_i,
    input  logic                                   ems_enable_i,
    input  logic [1:0]                             ems_base_sel_i,
    input  xt_periph_pkg::data_t                   data_i,
    input  logic                                   data_valid_i,
    input  logic [3:0]                             ems_win_i,
    input  xt_periph_pkg::ems_page_t [3:0]         ems_map_i,
    input  logic [3:0]                             ems_ena_i,
    output int                                     error_count_o,
    output int                                     check_count_o
);

    int errors = 0;
    int checks = 0;

    // Reference state
    xt_periph_pkg::data_t          lpt_ref;
    xt_periph_pkg::data_t          nmi_ref;
    xt_periph_pkg::ems_page_t [3:0] page_ref;
    logic [3:0]                    ena_ref;
    logic                          pend_valid;
    xt_periph_pkg::ems_slot_t      pend_slot;
    xt_periph_pkg::ems_page_t      pend_page;
    logic                          pend_ena;
    logic                          exp_valid;
    xt_periph_pkg::data_t          exp_data;

    logic                          io_wr_now;
    xt_periph_pkg::port_addr_t     port_now;
    xt_periph_pkg::data_t          wr_data;
    xt_periph_pkg::ems_slot_t      wr_slot;

    assign error_count_o = errors;
    assign check_count_o = checks;

    function automatic logic in_range(input xt_periph_pkg::port_addr_t port,
                                      input xt_periph_pkg::port_addr_t base,
                                      input int count);
        return (int'(port) >= int'(base)) && (int'(port) < int'(base) + count);
    endfunction

    // Valid flag and byte that a read at this edge should return
    function automatic logic [8:0] expected_read(input xt_periph_pkg::cpu_bus_t bus,
                                                 input logic tandy,
                                                 input logic ems_en);
        xt_periph_pkg::port_addr_t port;
        xt_periph_pkg::ems_slot_t  slot;
        port = bus.address[15:0];
        slot = bus.address[1:0];
        if (bus.address_enable_n || bus.io_read_n)
            return 9'h000;
        if (ems_en && in_range(port, xt_periph_pkg::EMS_PORT_DEFAULT, 4)) begin
            if (ena_ref[slot])
                return {2'b10, page_ref[slot]};
            return {1'b1, xt_periph_pkg::EMS_UNMAPPED};
        end
        if (port == xt_periph_pkg::LPT_PORT_DEFAULT)
            return {1'b1, lpt_ref};
        if (tandy && in_range(port, xt_periph_pkg::NMI_PORT_DEFAULT, 8))
            return {1'b1, nmi_ref};
        return 9'h000;
    endfunction

    function automatic logic [3:0] expected_windows(input xt_periph_pkg::cpu_bus_t bus,
                                                    input logic [1:0] base_sel);
        logic [3:0] base;
        logic [3:0] win;
        win = 4'b0000;
        case (base_sel)
            2'd0:    base = 4'hA;
            2'd1:    base = 4'hC;
            default: base = 4'hD;
        endcase
        if (!bus.address_enable_n && !bus.memory_read_n && bus.io_read_n && bus.io_write_n
            && bus.address[19:16] == base)
            win[bus.address[15:14]] = ena_ref[bus.address[15:14]];
        return win;
    endfunction

    task automatic compare(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error at time %0t: %s is %0h, expected %0h", $time, name, actual,
                     expected);
        end
    endtask

    // Sampled at the rising edge, so outputs show what the previous edge registered
    always @(posedge clock) begin
        if (reset) begin
            lpt_ref    = 8'hFF;
            nmi_ref    = 8'hFF;
            page_ref   = '0;
            ena_ref    = 4'b0000;
            pend_valid = 1'b0;
            exp_valid  = 1'b0;
            exp_data   = 8'h00;
        end
        else begin
            compare("data_valid_o", data_valid_i, exp_valid);
            compare("data_o", data_i, exp_data);
            compare("ems_map_o", ems_map_i, page_ref);
            compare("ems_ena_o", ems_ena_i, ena_ref);
            compare("ems_win_o", ems_win_i, expected_windows(cpu_bus_i, ems_base_sel_i));

            {exp_valid, exp_data} = expected_read(cpu_bus_i, tandy_video_i, ems_enable_i);

            // EMS write from the previous edge lands now
            if (pend_valid) begin
                page_ref[pend_slot] = pend_page;
                ena_ref[pend_slot]  = pend_ena;
            end
            pend_valid = 1'b0;

            io_wr_now = !cpu_bus_i.address_enable_n && !cpu_bus_i.io_write_n;
            port_now  = cpu_bus_i.address[15:0];
            wr_data   = cpu_bus_i.write_data;
            wr_slot   = cpu_bus_i.address[1:0];

            if (io_wr_now && ems_enable_i
                && in_range(port_now, xt_periph_pkg::EMS_PORT_DEFAULT, 4)) begin
                pend_valid = 1'b1;
                pend_slot  = wr_slot;
                if (wr_data == 8'hFF) begin
                    pend_page = 7'h7F;
                    pend_ena  = 1'b0;
                end
                else if (wr_data < 8'h80) begin
                    pend_page = wr_data[6:0];
                    pend_ena  = 1'b1;
                end
                else begin
                    pend_page = page_ref[wr_slot];
                    pend_ena  = ena_ref[wr_slot];
                end
            end
            if (io_wr_now && port_now == xt_periph_pkg::LPT_PORT_DEFAULT)
                lpt_ref = wr_data;
            if (io_wr_now && tandy_video_i
                && in_range(port_now, xt_periph_pkg::NMI_PORT_DEFAULT, 8))
                nmi_ref = wr_data;
        end
    end

endmodule

`default_nettype wire

// File: hdl/xt_peripherals.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// XT peripherals, I/O port side
// EMS page mapping, printer and NMI-mask latches
// and registered read-back on the CPU bus
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module xt_peripherals #(
    parameter xt_periph_pkg::port_addr_t EMS_PORT = xt_periph_pkg::EMS_PORT_DEFAULT,
    parameter xt_periph_pkg::port_addr_t LPT_PORT = xt_periph_pkg::LPT_PORT_DEFAULT,
    parameter xt_periph_pkg::port_addr_t NMI_PORT = xt_periph_pkg::NMI_PORT_DEFAULT
) (
    input  logic                                              clock,
    input  logic                                              reset,
    // CPU bus
    input  xt_periph_pkg::cpu_bus_t                           cpu_bus_i,
    output xt_periph_pkg::data_t                              data_o,
    output logic                                              data_valid_o,
    // Configuration
    input  logic                                              tandy_video_i,
    input  logic                                              ems_enable_i,
    input  logic [1:0]                                        ems_base_sel_i,
    // EMS windows
    output logic [xt_periph_pkg::EMS_SLOTS-1:0]               ems_win_o,
    output xt_periph_pkg::ems_page_t [xt_periph_pkg::EMS_SLOTS-1:0] ems_map_o,
    output logic [xt_periph_pkg::EMS_SLOTS-1:0]               ems_ena_o
);

    xt_periph_pkg::port_sel_t sel;
    xt_periph_pkg::data_t     ems_rd_data;
    xt_periph_pkg::data_t     lpt_data;
    xt_periph_pkg::data_t     nmi_mask;

    port_decoder #(
        .EMS_PORT       (EMS_PORT),
        .LPT_PORT       (LPT_PORT),
        .NMI_PORT       (NMI_PORT)
    ) u_port_decoder (
        .cpu_bus_i      (cpu_bus_i),
        .ems_enable_i   (ems_enable_i),
        .tandy_video_i  (tandy_video_i),
        .ems_base_sel_i (ems_base_sel_i),
        .sel_o          (sel),
        .ems_base_o     ()
    );

    ems_mapper u_ems_mapper (
        .clock          (clock),
        .reset          (reset),
        .sel_i          (sel),
        .cpu_bus_i      (cpu_bus_i),
        .map_o          (ems_map_o),
        .ena_o          (ems_ena_o),
        .win_o          (ems_win_o),
        .rd_data_o      (ems_rd_data)
    );

    port_latches u_port_latches (
        .clock          (clock),
        .reset          (reset),
        .sel_i          (sel),
        .wr_data_i      (cpu_bus_i.write_data),
        .lpt_data_o     (lpt_data),
        .nmi_mask_o     (nmi_mask)
    );

    read_mux u_read_mux (
        .clock          (clock),
        .reset          (reset),
        .sel_i          (sel),
        .ems_data_i     (ems_rd_data),
        .lpt_data_i     (lpt_data),
        .nmi_data_i     (nmi_mask),
        .data_o         (data_o),
        .data_valid_o   (data_valid_o)
    );

endmodule

`default_nettype wire

// File: hdl/read_mux.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Read-back multiplexer
// Registers the byte of the active read target and
// its valid flag onto the CPU data bus
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module read_mux (
    input  logic                     clock,
    input  logic                     reset,
    input  xt_periph_pkg::port_sel_t sel_i,
    input  xt_periph_pkg::data_t     ems_data_i,
    input  xt_periph_pkg::data_t     lpt_data_i,
    input  xt_periph_pkg::data_t     nmi_data_i,
    output xt_periph_pkg::data_t     data_o,
    output logic                     data_valid_o
);

    xt_periph_pkg::data_t next_data;
    logic                 next_valid;

    // Priority EMS, printer, NMI mask
    always_comb begin
        next_data  = '0;
        next_valid = 1'b1;
        if (sel_i.ems_rd)
            next_data = ems_data_i;
        else if (sel_i.lpt_rd)
            next_data = lpt_data_i;
        else if (sel_i.nmi_rd)
            next_data = nmi_data_i;
        else
            next_valid = 1'b0;
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            data_o       <= '0;
            data_valid_o <= 1'b0;
        end
        else begin
            data_o       <= next_data;
            data_valid_o <= next_valid;
        end
    end

endmodule

`default_nettype wire

// File: hdl/port_latches.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Port latches
// Printer data byte and Tandy NMI-mask byte
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module port_latches (
    input  logic                     clock,
    input  logic                     reset,
    input  xt_periph_pkg::port_sel_t sel_i,
    input  xt_periph_pkg::data_t     wr_data_i,
    output xt_periph_pkg::data_t     lpt_data_o,
    output xt_periph_pkg::data_t     nmi_mask_o
);

    // Printer data at 378h
    always_ff @(posedge clock, posedge reset) begin
        if (reset)
            lpt_data_o <= xt_periph_pkg::LATCH_RESET;
        else if (sel_i.lpt_wr)
            lpt_data_o <= wr_data_i;
    end

    // NMI mask, decoder already gates it with Tandy mode
    always_ff @(posedge clock, posedge reset) begin
        if (reset)
            nmi_mask_o <= xt_periph_pkg::LATCH_RESET;
        else if (sel_i.nmi_wr)
            nmi_mask_o <= wr_data_i;
    end

endmodule

`default_nettype wire

// File: ems/ems_mapper.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// EMS mapper
// Four page registers behind a one-stage write
// pipeline, window selects and page read-back
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module ems_mapper (
    input  logic                                              clock,
    input  logic                                              reset,
    input  xt_periph_pkg::port_sel_t                          sel_i,
    input  xt_periph_pkg::cpu_bus_t                           cpu_bus_i,
    output xt_periph_pkg::ems_page_t [xt_periph_pkg::EMS_SLOTS-1:0] map_o,
    output logic [xt_periph_pkg::EMS_SLOTS-1:0]               ena_o,
    output logic [xt_periph_pkg::EMS_SLOTS-1:0]               win_o,
    output xt_periph_pkg::data_t                              rd_data_o
);

    xt_periph_pkg::ems_slot_t slot;
    xt_periph_pkg::data_t     wr_data;
    xt_periph_pkg::ems_page_t cur_page;
    logic                     cur_ena;
    xt_periph_pkg::ems_page_t next_page;
    logic                     next_ena;

    // Pending write
    logic                     pend_valid_q;
    xt_periph_pkg::ems_slot_t pend_slot_q;
    xt_periph_pkg::ems_page_t pend_page_q;
    logic                     pend_ena_q;

    assign slot    = cpu_bus_i.address[1:0];
    assign wr_data = cpu_bus_i.write_data;

    // Current entry, taking a not yet committed write into account
    always_comb begin
        if (pend_valid_q && (pend_slot_q == slot)) begin
            cur_page = pend_page_q;
            cur_ena  = pend_ena_q;
        end
        else begin
            cur_page = map_o[slot];
            cur_ena  = ena_o[slot];
        end
    end

    // FFh unmaps, below 80h maps, anything else keeps the entry
    always_comb begin
        if (wr_data == xt_periph_pkg::EMS_UNMAPPED) begin
            next_page = wr_data[6:0];
            next_ena  = 1'b0;
        end
        else if (wr_data < xt_periph_pkg::EMS_MAP_LIMIT) begin
            next_page = wr_data[6:0];
            next_ena  = 1'b1;
        end
        else begin
            next_page = cur_page;
            next_ena  = cur_ena;
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset)
            pend_valid_q <= 1'b0;
        else
            pend_valid_q <= sel_i.ems_wr;
    end

    always_ff @(posedge clock) begin
        if (sel_i.ems_wr) begin
            pend_slot_q <= slot;
            pend_page_q <= next_page;
            pend_ena_q  <= next_ena;
        end
    end

    // Register bank commit, one cycle after capture
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            map_o <= '0;
            ena_o <= '0;
        end
        else if (pend_valid_q) begin
            map_o[pend_slot_q] <= pend_page_q;
            ena_o[pend_slot_q] <= pend_ena_q;
        end
    end

    always_comb begin
        for (int i = 0; i < xt_periph_pkg::EMS_SLOTS; i++) begin
            win_o[i] = sel_i.win_hit && (sel_i.win_slot == i) && ena_o[i];
        end
    end

    assign rd_data_o = ena_o[slot] ? {1'b0, map_o[slot]} : xt_periph_pkg::EMS_UNMAPPED;

endmodule

`default_nettype wire

// File: hdl/port_decoder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Port decoder
// Turns CPU bus cycles into per-target read/write
// strobes and EMS memory window hits
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module port_decoder #(
    parameter xt_periph_pkg::port_addr_t EMS_PORT = xt_periph_pkg::EMS_PORT_DEFAULT,
    parameter xt_periph_pkg::port_addr_t LPT_PORT = xt_periph_pkg::LPT_PORT_DEFAULT,
    parameter xt_periph_pkg::port_addr_t NMI_PORT = xt_periph_pkg::NMI_PORT_DEFAULT
) (
    input  xt_periph_pkg::cpu_bus_t  cpu_bus_i,
    input  logic                     ems_enable_i,
    input  logic                     tandy_video_i,
    input  logic [1:0]               ems_base_sel_i,
    output xt_periph_pkg::port_sel_t sel_o,
    output xt_periph_pkg::ems_base_t ems_base_o
);

    xt_periph_pkg::port_addr_t port;
    logic                      io_rd;
    logic                      io_wr;
    logic                      mem_cycle;
    logic                      ems_hit;
    logic                      lpt_hit;
    logic                      nmi_hit;

    assign port = cpu_bus_i.address[15:0];

    // I/O strobes only count while AEN is low
    assign io_rd = ~cpu_bus_i.address_enable_n & ~cpu_bus_i.io_read_n;
    assign io_wr = ~cpu_bus_i.address_enable_n & ~cpu_bus_i.io_write_n;

    assign mem_cycle = ~cpu_bus_i.address_enable_n & ~cpu_bus_i.memory_read_n
                     & cpu_bus_i.io_read_n & cpu_bus_i.io_write_n;

    // Four EMS ports, one printer port, eight NMI ports
    assign ems_hit = ems_enable_i && (port[15:2] == EMS_PORT[15:2]);
    assign lpt_hit = (port == LPT_PORT);
    assign nmi_hit = tandy_video_i && (port[15:3] == NMI_PORT[15:3]);

    always_comb begin
        case (ems_base_sel_i)
            2'b00:   ems_base_o = xt_periph_pkg::EMS_BASE_A;
            2'b01:   ems_base_o = xt_periph_pkg::EMS_BASE_C;
            default: ems_base_o = xt_periph_pkg::EMS_BASE_D;
        endcase
    end

    always_comb begin
        sel_o.ems_wr   = ems_hit & io_wr;
        sel_o.ems_rd   = ems_hit & io_rd;
        sel_o.lpt_wr   = lpt_hit & io_wr;
        sel_o.lpt_rd   = lpt_hit & io_rd;
        sel_o.nmi_wr   = nmi_hit & io_wr;
        sel_o.nmi_rd   = nmi_hit & io_rd;
        // 64 KB EMS range, 16 KB per slot
        sel_o.win_hit  = mem_cycle && (cpu_bus_i.address[19:16] == ems_base_o);
        sel_o.win_slot = cpu_bus_i.address[15:14];
    end

endmodule

`default_nettype wire

// File: common/xt_periph_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// XT peripheral port block shared definitions
// Bus widths, bus and select bundles, port constants
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package xt_periph_pkg;

    localparam int ADDR_W     = 20;
    localparam int PORT_W     = 16;
    localparam int DATA_W     = 8;
    localparam int EMS_PAGE_W = 7;
    localparam int EMS_SLOTS  = 4;

    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [PORT_W-1:0]     port_addr_t;
    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [EMS_PAGE_W-1:0] ems_page_t;
    typedef logic [1:0]            ems_slot_t;
    typedef logic [3:0]            ems_base_t;

    // Everything the CPU side drives in one cycle
    typedef struct packed {
        addr_t address;
        data_t write_data;
        logic  io_read_n;
        logic  io_write_n;
        logic  memory_read_n;
        logic  address_enable_n;
    } cpu_bus_t;

    // Decoded strobes, one pair per target
    typedef struct packed {
        logic      ems_wr;
        logic      ems_rd;
        logic      lpt_wr;
        logic      lpt_rd;
        logic      nmi_wr;
        logic      nmi_rd;
        logic      win_hit;
        ems_slot_t win_slot;
    } port_sel_t;

    // Default port bases
    localparam port_addr_t EMS_PORT_DEFAULT = 16'h0260;
    localparam port_addr_t LPT_PORT_DEFAULT = 16'h0378;
    localparam port_addr_t NMI_PORT_DEFAULT = 16'h00A0;

    // EMS segment nibbles A000h, C000h, D000h
    localparam ems_base_t EMS_BASE_A = 4'hA;
    localparam ems_base_t EMS_BASE_C = 4'hC;
    localparam ems_base_t EMS_BASE_D = 4'hD;

    // Unmap command, also read value of a disabled page
    localparam data_t EMS_UNMAPPED  = 8'hFF;
    // Data below this maps a page
    localparam data_t EMS_MAP_LIMIT = 8'h80;

    // Latch contents after reset
    localparam data_t LATCH_RESET = 8'hFF;

endpackage

`default_nettype wire
